// File: include/rv_core_settings.svh
// core widths and register file sizing for the three-stage pipeline
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// data path width
`define RV_XLEN       32

// register file
`define RV_REG_ADDR_W 5
`define RV_REG_COUNT  32

`endif

// File: logic/rv_core_pkg.sv
// shared types for the pipeline: decoded operations, immediate formats, operand sources
package rv_core_pkg;

    // one member per supported instruction, zero is the bubble
    typedef enum logic [5:0] {
        OP_INVALID = 6'd0,
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
        OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
        OP_SLLI, OP_SRLI, OP_SRAI, OP_SLTI, OP_SLTIU,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_CNTZ,    // count trailing zeros
        OP_CNTP,    // population count
        OP_RVRS     // bit reverse
    } op_e;

    typedef enum logic [2:0] {
        IMM_NONE,   // R-type, no immediate
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_J,
        IMM_U
    } imm_fmt_e;

    // where decode takes an operand from
    typedef enum logic [1:0] {
        FWD_REG,    // register file read
        FWD_EXEC,   // execute stage alu output, not yet registered
        FWD_RESULT  // registered execute result
    } fwd_sel_e;

endpackage

// File: logic/reg_file.sv
// register file with two combinational read ports, one write port and write-through
`timescale 1ns/100ps
`include "rv_core_settings.svh"

module reg_file (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic [`RV_REG_ADDR_W-1:0] rd1_addr_i,
    input  logic [`RV_REG_ADDR_W-1:0] rd2_addr_i,
    output logic [`RV_XLEN-1:0]       rd1_data_o,
    output logic [`RV_XLEN-1:0]       rd2_data_o,
    input  logic                      wr_en_i,
    input  logic [`RV_REG_ADDR_W-1:0] wr_addr_i,
    input  logic [`RV_XLEN-1:0]       wr_data_i
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    // x0 reads zero, a same-cycle write is passed straight through
    function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wr_en_i && wr_addr_i == addr) begin
            return wr_data_i;
        end
        return regs[addr];
    endfunction

    assign rd1_data_o = read_port(rd1_addr_i);
    assign rd2_data_o = read_port(rd2_addr_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

// File: logic/decode_stage.sv
// decode stage: instruction decode, immediate build and forwarded operand select
`timescale 1ns/100ps
`include "rv_core_settings.svh"

module decode_stage import rv_core_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic [31:0]               instr_i,
    input  logic                      instr_valid_i,
    input  logic [`RV_XLEN-1:0]       pc_i,
    input  logic [`RV_XLEN-1:0]       rd1_data_i,
    input  logic [`RV_XLEN-1:0]       rd2_data_i,
    input  logic [`RV_XLEN-1:0]       alu_data_i,   // one ahead
    input  logic [`RV_REG_ADDR_W-1:0] ex_rd_i,      // two ahead
    input  logic                      ex_wr_i,
    input  logic [`RV_XLEN-1:0]       ex_data_i,
    output logic [`RV_REG_ADDR_W-1:0] rs1_addr_o,
    output logic [`RV_REG_ADDR_W-1:0] rs2_addr_o,
    output logic                      dec_valid_o,
    output op_e                       dec_op_o,
    output logic [`RV_REG_ADDR_W-1:0] dec_rd_o,
    output logic [`RV_XLEN-1:0]       dec_a_o,
    output logic [`RV_XLEN-1:0]       dec_b_o,
    output logic [`RV_XLEN-1:0]       dec_imm_o,
    output logic [`RV_XLEN-1:0]       dec_pc_o
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    op_e                 op;
    imm_fmt_e            fmt;
    logic [`RV_XLEN-1:0] imm;
    fwd_sel_e            sel_a;
    fwd_sel_e            sel_b;
    logic [`RV_XLEN-1:0] opnd_a;
    logic [`RV_XLEN-1:0] opnd_b;

    assign opcode     = instr_i[6:0];
    assign funct3     = instr_i[14:12];
    assign funct7     = instr_i[31:25];
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    always_comb begin
        op  = OP_INVALID;
        fmt = IMM_NONE;
        case (opcode)
            7'b0110011: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = OP_ADD;
                    10'b0100000_000: op = OP_SUB;
                    10'b0000000_001: op = OP_SLL;
                    10'b0000000_010: op = OP_SLT;
                    10'b0000000_011: op = OP_SLTU;
                    10'b0000000_100: op = OP_XOR;
                    10'b0000000_101: op = OP_SRL;
                    10'b0100000_101: op = OP_SRA;
                    10'b0000000_110: op = OP_OR;
                    10'b0000000_111: op = OP_AND;
                    default:         op = OP_INVALID;
                endcase
            end
            7'b0010011: begin
                fmt = IMM_I;
                // unary bit ops share op-imm, told apart by funct7 and the rs2 field
                casez ({funct3, funct7, instr_i[24:20]})
                    15'b000_???????_?????: op = OP_ADDI;
                    15'b010_???????_?????: op = OP_SLTI;
                    15'b011_???????_?????: op = OP_SLTIU;
                    15'b100_???????_?????: op = OP_XORI;
                    15'b110_???????_?????: op = OP_ORI;
                    15'b111_???????_?????: op = OP_ANDI;
                    15'b001_0000000_?????: op = OP_SLLI;
                    15'b001_0110000_00001: op = OP_CNTZ;
                    15'b001_0110000_00010: op = OP_CNTP;
                    15'b101_0000000_?????: op = OP_SRLI;
                    15'b101_0100000_?????: op = OP_SRAI;
                    15'b101_0110100_11111: op = OP_RVRS;
                    default:               op = OP_INVALID;
                endcase
            end
            7'b1100011: begin
                fmt = IMM_B;
                case (funct3)
                    3'b000:  op = OP_BEQ;
                    3'b001:  op = OP_BNE;
                    3'b100:  op = OP_BLT;
                    3'b101:  op = OP_BGE;
                    3'b110:  op = OP_BLTU;
                    3'b111:  op = OP_BGEU;
                    default: op = OP_INVALID;
                endcase
            end
            7'b0110111: begin
                fmt = IMM_U;
                op  = OP_LUI;
            end
            7'b0010111: begin
                fmt = IMM_U;
                op  = OP_AUIPC;
            end
            7'b1101111: begin
                fmt = IMM_J;
                op  = OP_JAL;
            end
            7'b1100111: begin
                fmt = IMM_I;
                op  = (funct3 == 3'b000) ? OP_JALR : OP_INVALID;
            end
            default: op = OP_INVALID;
        endcase

        if (!instr_valid_i) begin
            op = OP_INVALID;    // bubble
        end
    end

    always_comb begin
        case (fmt)
            IMM_I:   imm = {{20{instr_i[31]}}, instr_i[31:20]};
            IMM_B:   imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            IMM_J:   imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
            IMM_U:   imm = {instr_i[31:12], 12'b0};
            default: imm = '0;
        endcase
    end

    // nearest older writer wins, x0 never forwards
    function automatic fwd_sel_e fwd_pick(input logic [`RV_REG_ADDR_W-1:0] rs);
        fwd_sel_e sel;
        sel = FWD_REG;
        if (rs != '0) begin
            if (dec_valid_o && dec_rd_o == rs) begin
                sel = FWD_EXEC;
            end else if (ex_wr_i && ex_rd_i == rs) begin
                sel = FWD_RESULT;
            end
        end
        return sel;
    endfunction

    function automatic logic [`RV_XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                    input logic [`RV_XLEN-1:0] reg_val);
        case (sel)
            FWD_EXEC:   return alu_data_i;
            FWD_RESULT: return ex_data_i;
            default:    return reg_val;
        endcase
    endfunction

    always_comb begin
        sel_a  = fwd_pick(rs1_addr_o);
        sel_b  = fwd_pick(rs2_addr_o);
        opnd_a = fwd_mux(sel_a, rd1_data_i);
        opnd_b = (fmt == IMM_I || fmt == IMM_U) ? imm : fwd_mux(sel_b, rd2_data_i);
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dec_valid_o <= 1'b0;
            dec_op_o    <= OP_INVALID;
            dec_rd_o    <= '0;
        end else begin
            dec_valid_o <= (op != OP_INVALID);
            dec_op_o    <= op;
            dec_rd_o    <= (fmt == IMM_B) ? '0 : instr_i[11:7];  // branches write nothing
        end
    end

    always_ff @(posedge clk_i) begin
        dec_a_o   <= opnd_a;
        dec_b_o   <= opnd_b;
        dec_imm_o <= imm;
        dec_pc_o  <= pc_i;
    end

endmodule

// File: logic/execute_stage.sv
// execute stage: alu, custom bit ops and branch resolution
`timescale 1ns/100ps
`include "rv_core_settings.svh"

module execute_stage import rv_core_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      dec_valid_i,
    input  op_e                       dec_op_i,
    input  logic [`RV_REG_ADDR_W-1:0] dec_rd_i,
    input  logic [`RV_XLEN-1:0]       dec_a_i,
    input  logic [`RV_XLEN-1:0]       dec_b_i,
    input  logic [`RV_XLEN-1:0]       dec_imm_i,
    input  logic [`RV_XLEN-1:0]       dec_pc_i,
    output logic [`RV_XLEN-1:0]       alu_data_o,   // unregistered, for forwarding
    output logic                      ex_valid_o,
    output logic                      ex_wr_o,
    output logic [`RV_REG_ADDR_W-1:0] ex_rd_o,
    output logic [`RV_XLEN-1:0]       ex_data_o,
    output logic                      branch_taken_o,
    output logic [`RV_XLEN-1:0]       branch_target_o
);

    logic                writes_rd;
    logic                take;
    logic [`RV_XLEN-1:0] target;
    logic [`RV_XLEN-1:0] jalr_sum;

    // lowest set bit wins, zero input gives xlen
    function automatic logic [`RV_XLEN-1:0] count_tz(input logic [`RV_XLEN-1:0] v);
        logic [`RV_XLEN-1:0] n;
        n = `RV_XLEN;
        for (int i = `RV_XLEN - 1; i >= 0; i--) begin
            if (v[i]) begin
                n = `RV_XLEN'(i);
            end
        end
        return n;
    endfunction

    function automatic logic [`RV_XLEN-1:0] count_pop(input logic [`RV_XLEN-1:0] v);
        logic [`RV_XLEN-1:0] n;
        n = '0;
        for (int i = 0; i < `RV_XLEN; i++) begin
            n = n + `RV_XLEN'(v[i]);
        end
        return n;
    endfunction

    function automatic logic [`RV_XLEN-1:0] bit_rev(input logic [`RV_XLEN-1:0] v);
        logic [`RV_XLEN-1:0] r;
        for (int i = 0; i < `RV_XLEN; i++) begin
            r[i] = v[`RV_XLEN-1-i];
        end
        return r;
    endfunction

    always_comb begin
        case (dec_op_i)
            OP_ADD, OP_ADDI:   alu_data_o = dec_a_i + dec_b_i;
            OP_SUB:            alu_data_o = dec_a_i - dec_b_i;
            OP_AND, OP_ANDI:   alu_data_o = dec_a_i & dec_b_i;
            OP_OR, OP_ORI:     alu_data_o = dec_a_i | dec_b_i;
            OP_XOR, OP_XORI:   alu_data_o = dec_a_i ^ dec_b_i;
            OP_SLL, OP_SLLI:   alu_data_o = dec_a_i << dec_b_i[4:0];
            OP_SRL, OP_SRLI:   alu_data_o = dec_a_i >> dec_b_i[4:0];
            OP_SRA, OP_SRAI:   alu_data_o = $signed(dec_a_i) >>> dec_b_i[4:0];
            OP_SLT, OP_SLTI:   alu_data_o = `RV_XLEN'($signed(dec_a_i) < $signed(dec_b_i));
            OP_SLTU, OP_SLTIU: alu_data_o = `RV_XLEN'(dec_a_i < dec_b_i);
            OP_LUI:            alu_data_o = dec_imm_i;
            OP_AUIPC:          alu_data_o = dec_pc_i + dec_imm_i;
            OP_JAL, OP_JALR:   alu_data_o = dec_pc_i + `RV_XLEN'(4);   // link
            OP_CNTZ:           alu_data_o = count_tz(dec_a_i);
            OP_CNTP:           alu_data_o = count_pop(dec_a_i);
            OP_RVRS:           alu_data_o = bit_rev(dec_a_i);
            default:           alu_data_o = '0;
        endcase
    end

    assign jalr_sum  = dec_a_i + dec_imm_i;
    assign writes_rd = !(dec_op_i inside {OP_INVALID, OP_BEQ, OP_BNE, OP_BLT,
                                          OP_BGE, OP_BLTU, OP_BGEU});

    always_comb begin
        take   = 1'b0;
        target = dec_pc_i + dec_imm_i;
        case (dec_op_i)
            OP_BEQ:  take = (dec_a_i == dec_b_i);
            OP_BNE:  take = (dec_a_i != dec_b_i);
            OP_BLT:  take = ($signed(dec_a_i) < $signed(dec_b_i));
            OP_BGE:  take = ($signed(dec_a_i) >= $signed(dec_b_i));
            OP_BLTU: take = (dec_a_i < dec_b_i);
            OP_BGEU: take = (dec_a_i >= dec_b_i);
            OP_JAL:  take = 1'b1;
            OP_JALR: begin
                take   = 1'b1;
                target = {jalr_sum[`RV_XLEN-1:1], 1'b0};
            end
            default: take = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex_valid_o     <= 1'b0;
            ex_wr_o        <= 1'b0;
            branch_taken_o <= 1'b0;
        end else begin
            ex_valid_o     <= dec_valid_i;
            ex_wr_o        <= dec_valid_i && writes_rd;
            branch_taken_o <= dec_valid_i && take;
        end
    end

    always_ff @(posedge clk_i) begin
        ex_rd_o         <= dec_rd_i;
        ex_data_o       <= alu_data_o;
        branch_target_o <= target;
    end

endmodule

// File: logic/result_stage.sv
// result stage: writeback register and retired instruction counter
`timescale 1ns/100ps
`include "rv_core_settings.svh"

module result_stage (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      ex_valid_i,
    input  logic                      ex_wr_i,
    input  logic [`RV_REG_ADDR_W-1:0] ex_rd_i,
    input  logic [`RV_XLEN-1:0]       ex_data_i,
    output logic                      wb_en_o,
    output logic [`RV_REG_ADDR_W-1:0] wb_rd_o,
    output logic [`RV_XLEN-1:0]       wb_data_o,
    output logic [31:0]               retire_count_o
);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_en_o        <= 1'b0;
            retire_count_o <= '0;
        end else begin
            wb_en_o <= ex_valid_i && ex_wr_i && (ex_rd_i != '0);   // x0 writes dropped here
            if (ex_valid_i) begin
                retire_count_o <= retire_count_o + 32'd1;   // branches retire too
            end
        end
    end

    always_ff @(posedge clk_i) begin
        wb_rd_o   <= ex_rd_i;
        wb_data_o <= ex_data_i;
    end

endmodule

// File: logic/core_pipe.sv
// top of the three-stage integer pipeline with its register file
`timescale 1ns/100ps
`include "rv_core_settings.svh"

module core_pipe import rv_core_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic [31:0]               instr_i,
    input  logic                      instr_valid_i,
    input  logic [`RV_XLEN-1:0]       pc_i,
    output logic                      wb_en_o,
    output logic [`RV_REG_ADDR_W-1:0] wb_rd_o,
    output logic [`RV_XLEN-1:0]       wb_data_o,
    output logic                      branch_taken_o,
    output logic [`RV_XLEN-1:0]       branch_target_o,
    output logic [31:0]               retire_count_o
);

    // register file read side
    logic [`RV_REG_ADDR_W-1:0] rs1_addr;
    logic [`RV_REG_ADDR_W-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]       rd1_data;
    logic [`RV_XLEN-1:0]       rd2_data;

    // decode to execute
    logic                      dec_valid;
    op_e                       dec_op;
    logic [`RV_REG_ADDR_W-1:0] dec_rd;
    logic [`RV_XLEN-1:0]       dec_a;
    logic [`RV_XLEN-1:0]       dec_b;
    logic [`RV_XLEN-1:0]       dec_imm;
    logic [`RV_XLEN-1:0]       dec_pc;

    // execute to result, also fed back for forwarding
    logic [`RV_XLEN-1:0]       alu_data;
    logic                      ex_valid;
    logic                      ex_wr;
    logic [`RV_REG_ADDR_W-1:0] ex_rd;
    logic [`RV_XLEN-1:0]       ex_data;

    decode_stage u_decode (
        .clk_i(clk_i), .rst_i(rst_i),
        .instr_i(instr_i), .instr_valid_i(instr_valid_i), .pc_i(pc_i),
        .rd1_data_i(rd1_data), .rd2_data_i(rd2_data),
        .alu_data_i(alu_data), .ex_rd_i(ex_rd), .ex_wr_i(ex_wr), .ex_data_i(ex_data),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .dec_valid_o(dec_valid), .dec_op_o(dec_op), .dec_rd_o(dec_rd),
        .dec_a_o(dec_a), .dec_b_o(dec_b), .dec_imm_o(dec_imm), .dec_pc_o(dec_pc)
    );

    execute_stage u_execute (
        .clk_i(clk_i), .rst_i(rst_i),
        .dec_valid_i(dec_valid), .dec_op_i(dec_op), .dec_rd_i(dec_rd),
        .dec_a_i(dec_a), .dec_b_i(dec_b), .dec_imm_i(dec_imm), .dec_pc_i(dec_pc),
        .alu_data_o(alu_data), .ex_valid_o(ex_valid), .ex_wr_o(ex_wr),
        .ex_rd_o(ex_rd), .ex_data_o(ex_data),
        .branch_taken_o(branch_taken_o), .branch_target_o(branch_target_o)
    );

    result_stage u_result (
        .clk_i(clk_i), .rst_i(rst_i),
        .ex_valid_i(ex_valid), .ex_wr_i(ex_wr), .ex_rd_i(ex_rd), .ex_data_i(ex_data),
        .wb_en_o(wb_en_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o),
        .retire_count_o(retire_count_o)
    );

    // write port driven by the result stage, third-ahead reads bypass through it
    reg_file u_regs (
        .clk_i(clk_i), .rst_i(rst_i),
        .rd1_addr_i(rs1_addr), .rd2_addr_i(rs2_addr),
        .rd1_data_o(rd1_data), .rd2_data_o(rd2_data),
        .wr_en_i(wb_en_o), .wr_addr_i(wb_rd_o), .wr_data_i(wb_data_o)
    );

endmodule

// File: verification/core_pipe_tb.sv
// testbench for the three-stage core pipeline, directed tests against a register model
`timescale 1ns/100ps
`include "rv_core_settings.svh"

module core_pipe_tb import rv_core_pkg::*; ();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;

    // issue slots per test, in the order the tests run
    localparam int ISSUE_SLOTS = 4 * 23     // alu_ops
                               + 32         // dependent_chains
                               + 8          // x0_and_bubbles
                               + 4 * 5      // jumps_and_upper
                               + 5 * 10     // cond_branches
                               + 8 * 6      // bit_ops
                               + 3;         // drain

    localparam op_e R_OPS [10] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                   OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU};
    localparam op_e I_OPS [9] = '{OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLLI,
                                  OP_SRLI, OP_SRAI, OP_SLTI, OP_SLTIU};
    localparam op_e BR_OPS [6] = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};

    // what the outputs should show for one issue slot
    typedef struct {
        logic        wb;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        br;
        logic [31:0] tgt;
        logic [31:0] retire;
    } exp_t;

    logic                      clk_i;
    logic                      rst_i;
    logic [31:0]               instr_i;
    logic                      instr_valid_i;
    logic [`RV_XLEN-1:0]       pc_i;
    logic                      wb_en_o;
    logic [`RV_REG_ADDR_W-1:0] wb_rd_o;
    logic [`RV_XLEN-1:0]       wb_data_o;
    logic                      branch_taken_o;
    logic [`RV_XLEN-1:0]       branch_target_o;
    logic [31:0]               retire_count_o;

    logic [31:0] model_regs [32];
    logic [31:0] pc_model;
    logic [31:0] exp_retire;
    logic [31:0] rng_state;
    exp_t        exp_q [$];     // oldest first, last four slots
    string       cur_test;
    int          errors;
    int          checks;

    core_pipe dut0 (
        .clk_i(clk_i), .rst_i(rst_i),
        .instr_i(instr_i), .instr_valid_i(instr_valid_i), .pc_i(pc_i),
        .wb_en_o(wb_en_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o),
        .branch_taken_o(branch_taken_o), .branch_target_o(branch_target_o),
        .retire_count_o(retire_count_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [31:0] encode(input op_e op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [31:0] imm);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] i12;
        case (op)
            OP_SLL, OP_SLLI, OP_BNE, OP_CNTZ, OP_CNTP:          f3 = 3'b001;
            OP_SLT, OP_SLTI:                                    f3 = 3'b010;
            OP_SLTU, OP_SLTIU:                                  f3 = 3'b011;
            OP_XOR, OP_XORI, OP_BLT:                            f3 = 3'b100;
            OP_SRL, OP_SRLI, OP_SRA, OP_SRAI, OP_BGE, OP_RVRS:  f3 = 3'b101;
            OP_OR, OP_ORI, OP_BLTU:                             f3 = 3'b110;
            OP_AND, OP_ANDI, OP_BGEU:                           f3 = 3'b111;
            default:                                            f3 = 3'b000;
        endcase
        f7 = (op inside {OP_SUB, OP_SRA}) ? 7'b0100000 : 7'b0000000;
        // shifts and bit ops carry fixed upper immediate fields
        case (op)
            OP_SLLI, OP_SRLI: i12 = {7'b0000000, imm[4:0]};
            OP_SRAI:          i12 = {7'b0100000, imm[4:0]};
            OP_CNTZ:          i12 = 12'h601;
            OP_CNTP:          i12 = 12'h602;
            OP_RVRS:          i12 = 12'h69f;
            default:          i12 = imm[11:0];
        endcase
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU:
                return {f7, rs2, rs1, f3, rd, 7'b0110011};
            OP_LUI:   return {imm[31:12], rd, 7'b0110111};
            OP_AUIPC: return {imm[31:12], rd, 7'b0010111};
            OP_JAL:   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            OP_JALR:  return {i12, rs1, 3'b000, rd, 7'b1100111};
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:
                return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
            default:  return {i12, rs1, f3, rd, 7'b0010011};  // op-imm
        endcase
    endfunction

    // architectural result of one instruction
    function automatic logic [31:0] model_result(input op_e op, input logic [31:0] a,
                                                 input logic [31:0] b, input logic [31:0] pc,
                                                 input logic [31:0] imm);
        int n;
        case (op)
            OP_ADD, OP_ADDI:   return a + b;
            OP_SUB:            return a - b;
            OP_AND, OP_ANDI:   return a & b;
            OP_OR, OP_ORI:     return a | b;
            OP_XOR, OP_XORI:   return a ^ b;
            OP_SLL, OP_SLLI:   return a << b[4:0];
            OP_SRL, OP_SRLI:   return a >> b[4:0];
            OP_SRA, OP_SRAI:   return $signed(a) >>> b[4:0];
            OP_SLT, OP_SLTI:   return {31'b0, $signed(a) < $signed(b)};
            OP_SLTU, OP_SLTIU: return {31'b0, a < b};
            OP_LUI:            return imm;
            OP_AUIPC:          return pc + imm;
            OP_JAL, OP_JALR:   return pc + 32'd4;
            OP_CNTZ: begin
                n = 0;
                while (n < 32 && !a[n[4:0]]) begin
                    n++;
                end
                return 32'(n);
            end
            OP_CNTP:           return 32'($countones(a));
            OP_RVRS:           return {<<{a}};
            default:           return 32'd0;
        endcase
    endfunction

    function automatic exp_t idle_entry();
        exp_t e;
        e.wb     = 1'b0;
        e.rd     = 5'd0;
        e.data   = 32'd0;
        e.br     = 1'b0;
        e.tgt    = 32'd0;
        e.retire = exp_retire;  // count unchanged
        return e;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("ERROR %s %s: expected %h, actual %h", cur_test, what, expected, actual);
    endtask

    task automatic check_outputs();
        exp_t w;
        exp_t b;
        w = exp_q[0];   // three slots back
        b = exp_q[1];   // two slots back
        checks++;
        if (wb_en_o !== w.wb) begin
            report_mismatch("wb_en", 32'(w.wb), 32'(wb_en_o));
        end
        if (w.wb && wb_rd_o !== w.rd) begin
            report_mismatch("wb_rd", 32'(w.rd), 32'(wb_rd_o));
        end
        if (w.wb && wb_data_o !== w.data) begin
            report_mismatch("wb_data", w.data, wb_data_o);
        end
        if (branch_taken_o !== b.br) begin
            report_mismatch("branch_taken", 32'(b.br), 32'(branch_taken_o));
        end
        if (b.br && branch_target_o !== b.tgt) begin
            report_mismatch("branch_target", b.tgt, branch_target_o);
        end
        if (retire_count_o !== w.retire) begin
            report_mismatch("retire_count", w.retire, retire_count_o);
        end
    endtask

    // one slot per clock, outputs checked at the falling edge
    task automatic issue(input logic [31:0] instr, input logic valid, input exp_t e);
        @(posedge clk_i);
        instr_i       <= instr;
        instr_valid_i <= valid;
        pc_i          <= pc_model;
        pc_model = pc_model + 32'd4;
        exp_q.push_back(e);
        @(negedge clk_i);
        check_outputs();
        void'(exp_q.pop_front());
    endtask

    task automatic issue_bubble(input logic [31:0] instr, input logic valid);
        issue(instr, valid, idle_entry());
    endtask

    task automatic run_op(input op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [4:0] rs2, input logic [31:0] imm);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic        is_br;
        logic        is_r;
        exp_t        e;
        is_br = op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
        is_r  = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                           OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU};
        simm  = {{20{imm[11]}}, imm[11:0]};
        a     = model_regs[rs1];
        b     = (is_br || is_r) ? model_regs[rs2] : simm;
        case (op)
            OP_BEQ:          e.br = (a == b);
            OP_BNE:          e.br = (a != b);
            OP_BLT:          e.br = ($signed(a) < $signed(b));
            OP_BGE:          e.br = ($signed(a) >= $signed(b));
            OP_BLTU:         e.br = (a < b);
            OP_BGEU:         e.br = (a >= b);
            OP_JAL, OP_JALR: e.br = 1'b1;
            default:         e.br = 1'b0;
        endcase
        e.tgt  = (op == OP_JALR) ? ((a + simm) & ~32'd1) : (pc_model + imm);
        e.data = model_result(op, a, b, pc_model, imm);
        e.wb   = !is_br && rd != 5'd0;
        e.rd   = rd;
        exp_retire = exp_retire + 32'd1;
        e.retire   = exp_retire;
        if (e.wb) begin
            model_regs[rd] = e.data;
        end
        issue(encode(op, rd, rs1, rs2, imm), 1'b1, e);
    endtask

    task automatic load_reg(input logic [4:0] rd, input logic [31:0] val);
        logic [31:0] hi;
        hi = (val + 32'h0000_0800) & 32'hffff_f000;    // addi sign-extends the low part
        run_op(OP_LUI, rd, 5'd0, 5'd0, hi);
        run_op(OP_ADDI, rd, rd, 5'd0, {20'b0, val[11:0]});
    endtask

    task automatic pad(input int n);
        repeat (n) begin
            run_op(OP_ADDI, 5'd20, 5'd0, 5'd0, 32'd1);
        end
    endtask

    task automatic alu_ops();
        cur_test = "alu_ops";
        for (int k = 0; k < 4; k++) begin
            load_reg(5'd1, next_rand());
            load_reg(5'd2, next_rand());
            foreach (R_OPS[i]) begin
                run_op(R_OPS[i], 5'(5 + i), 5'd1, 5'd2, 32'd0);
            end
            foreach (I_OPS[i]) begin
                run_op(I_OPS[i], 5'(15 + i), 5'd1, 5'd0, next_rand());
            end
        end
    endtask

    task automatic dependent_chains();
        cur_test = "dependent_chains";
        for (int d = 1; d <= 4; d++) begin
            load_reg(5'd1, next_rand());
            run_op(OP_ADD, 5'd10, 5'd1, 5'd1, 32'd0);
            pad(d - 1);
            run_op(OP_SUB, 5'd11, 5'd1, 5'd10, 32'd0);     // x10 on rs2, d behind
            pad(d - 1);
            run_op(OP_XOR, 5'd12, 5'd11, 5'd10, 32'd0);    // x11 on rs1, d behind
        end
    endtask

    task automatic x0_and_bubbles();
        cur_test = "x0_and_bubbles";
        run_op(OP_ADDI, 5'd15, 5'd0, 5'd0, 32'd3);
        run_op(OP_ADDI, 5'd0, 5'd15, 5'd0, 32'd5);     // write to x0
        run_op(OP_ADD, 5'd16, 5'd0, 5'd0, 32'd0);
        run_op(OP_ADD, 5'd17, 5'd0, 5'd15, 32'd0);
        issue_bubble(encode(OP_ADDI, 5'd15, 5'd0, 5'd0, 32'd99), 1'b0);
        issue_bubble(32'h0000_0000, 1'b1);             // no such opcode
        issue_bubble({7'b1111111, 5'd1, 5'd2, 3'b000, 5'd15, 7'b0110011}, 1'b1);
        run_op(OP_ADD, 5'd18, 5'd15, 5'd0, 32'd0);     // x15 untouched by the bubbles
    endtask

    task automatic jumps_and_upper();
        logic [31:0] r;
        cur_test = "jumps_and_upper";
        repeat (4) begin
            run_op(OP_LUI, 5'd5, 5'd0, 5'd0, next_rand() & 32'hffff_f000);
            run_op(OP_AUIPC, 5'd6, 5'd0, 5'd0, next_rand() & 32'hffff_f000);
            r = next_rand();
            run_op(OP_JAL, 5'd7, 5'd0, 5'd0, {{11{r[20]}}, r[20:1], 1'b0});
            r = next_rand();
            run_op(OP_JALR, 5'd8, 5'd5, 5'd0, {{20{r[11]}}, r[11:0]});
            run_op(OP_ADD, 5'd9, 5'd7, 5'd8, 32'd0);   // both links forwarded
        end
    endtask

    task automatic cond_branches();
        logic [31:0] r;
        logic [31:0] va;
        logic [31:0] vb;
        cur_test = "cond_branches";
        for (int p = 0; p < 5; p++) begin
            va = next_rand() >> 2;
            case (p)
                0:       vb = va;
                1:       vb = va + 32'd5;
                2:       vb = va - 32'd5;
                3:       vb = va | 32'h8000_0000;   // signed less, unsigned greater
                default: vb = va;
            endcase
            if (p == 4) begin
                va = va | 32'h8000_0000;
            end
            load_reg(5'd1, va);
            load_reg(5'd2, vb);
            foreach (BR_OPS[i]) begin
                r = next_rand();
                run_op(BR_OPS[i], 5'd0, 5'd1, 5'd2, {{19{r[12]}}, r[12:1], 1'b0});
            end
        end
    endtask

    task automatic bit_ops();
        logic [31:0] v;
        cur_test = "bit_ops";
        for (int k = 0; k < 8; k++) begin
            v = (k == 0) ? 32'd0 : (k == 1) ? 32'hffff_ffff : next_rand();
            load_reg(5'd1, v);
            run_op(OP_CNTZ, 5'd10, 5'd1, 5'd0, 32'd0);
            run_op(OP_CNTP, 5'd11, 5'd1, 5'd0, 32'd0);
            run_op(OP_RVRS, 5'd12, 5'd1, 5'd0, 32'd0);
            run_op(OP_CNTZ, 5'd13, 5'd12, 5'd0, 32'd0);
        end
    endtask

    initial begin
        rst_i         = 1'b1;
        instr_i       = 32'd0;
        instr_valid_i = 1'b0;
        pc_i          = 32'd0;
        pc_model      = 32'h0000_1000;
        exp_retire    = 32'd0;
        rng_state     = 32'h58c7_43be;
        errors        = 0;
        checks        = 0;
        cur_test      = "reset";
        foreach (model_regs[i]) begin
            model_regs[i] = 32'd0;
        end
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
        repeat (3) exp_q.push_back(idle_entry());

        alu_ops();
        dependent_chains();
        x0_and_bubbles();
        jumps_and_upper();
        cond_branches();
        bit_ops();
        cur_test = "drain";
        repeat (3) issue_bubble(32'd0, 1'b0);

        $display("slots checked %0d, retired %0d, errors %0d", checks, exp_retire, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((RESET_CYCLES + ISSUE_SLOTS + 50) * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d issue slots", ISSUE_SLOTS);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: rv_core.f
+incdir+include
logic/rv_core_pkg.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/core_pipe.sv
verification/core_pipe_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile the core_pipe testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f rv_core.f --top-module core_pipe_tb \
    -Mdir obj_dir -o core_pipe_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/core_pipe_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# pass or fail comes from the log
if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
exit 0
